// File: verilog/video_pkg.sv
// Video pixel types and constants

package video_pkg;

   // ----------------------------------------------------------
   // Pixel and coordinate types
   // ----------------------------------------------------------
   typedef logic [3:0]  channel_t;   // One colour channel, 4 bit DAC
   typedef logic [11:0] rgb12_t;     // {red, green, blue}
   typedef logic [10:0] coord_t;     // Column or line number

   // ----------------------------------------------------------
   // Grey conversion
   // ----------------------------------------------------------
   // Weights sum to 16 so the divide is a shift by 4
   localparam int GRAY_WR = 5;       // Red weight
   localparam int GRAY_WG = 9;       // Green weight
   localparam int GRAY_WB = 2;       // Blue weight

   // ----------------------------------------------------------
   // Pattern constants
   // ----------------------------------------------------------
   localparam int SPRITE_SIZE = 8;   // Square edge in pixels
   localparam int NUM_BARS    = 8;   // Vertical colour bars

endpackage

// File: verilog/video_regs_pkg.sv
// Video control register map

package video_regs_pkg;

   // Wishbone bus types
   typedef logic [31:0] wb_data_t;   // Bus data
   typedef logic [7:0]  wb_addr_t;   // Byte address

   // ----------------------------------------------------------
   // Register offsets
   // ----------------------------------------------------------
   localparam wb_addr_t REG_CTRL         = 8'h00;  // Enables
   localparam wb_addr_t REG_BG_COLOR     = 8'h04;  // Background rgb12
   localparam wb_addr_t REG_SPRITE_POS   = 8'h08;  // y in 26:16, x in 10:0
   localparam wb_addr_t REG_SPRITE_COLOR = 8'h0C;  // Sprite rgb12
   localparam wb_addr_t REG_FRAME_CNT    = 8'h10;  // Read only

   // ----------------------------------------------------------
   // REG_CTRL bit positions
   // ----------------------------------------------------------
   localparam int CTRL_BAR_EN    = 0;
   localparam int CTRL_SPRITE_EN = 1;
   localparam int CTRL_GRAY_EN   = 2;

endpackage

// File: verilog/pixel_if.sv
// Pixel stream between pipeline stages

`timescale 1ns/1ps

interface pixel_if;

   import video_pkg::*;

   logic   de;      // Active area
   logic   hsync;   // Active low
   logic   vsync;   // Active low
   coord_t x;       // Column
   coord_t y;       // Line
   rgb12_t rgb;     // Pixel colour

   // Producing stage
   modport src (output de, hsync, vsync, x, y, rgb);

   // Consuming stage
   modport dst (input de, hsync, vsync, x, y, rgb);

endinterface

// File: verilog/video_cfg_if.sv
// Register values to the pipeline

`timescale 1ns/1ps

interface video_cfg_if;

   import video_pkg::*;

   logic   bar_en;
   logic   sprite_en;
   logic   gray_en;
   rgb12_t bg_color;       // Used with bars off
   coord_t sprite_x;       // Left column of square
   coord_t sprite_y;       // Top line of square
   rgb12_t sprite_color;

   modport regs (output bar_en, sprite_en, gray_en, bg_color,
                 sprite_x, sprite_y, sprite_color);
   modport user (input bar_en, sprite_en, gray_en, bg_color,
                 sprite_x, sprite_y, sprite_color);

endinterface

// File: verilog/video_ctrl_regs.sv
// Wishbone control registers

`timescale 1ns/1ps

module video_ctrl_regs (
   input  logic                      pixel_clk,
   input  logic                      reset,
   input  logic                      wb_cyc,
   input  logic                      wb_stb,
   input  logic                      wb_we,
   input  video_regs_pkg::wb_addr_t  wb_adr,
   input  video_regs_pkg::wb_data_t  wb_dat_w,
   output video_regs_pkg::wb_data_t  wb_dat_r,
   output logic                      wb_ack,
   input  logic                      frame_start,  // From vga_timing
   video_cfg_if.regs                 cfg
);

   import video_pkg::*;
   import video_regs_pkg::*;

   logic     bar_en_q, sprite_en_q, gray_en_q;
   rgb12_t   bg_color_q;
   coord_t   sprite_x_q, sprite_y_q;
   rgb12_t   sprite_color_q;
   wb_data_t frame_cnt_q;
   wb_data_t rd_data;
   logic     wb_req;

   // New access, ack not yet given
   assign wb_req = wb_cyc & wb_stb & ~wb_ack;

   // ----------------------------------------------------------
   // Read-back mux
   // ----------------------------------------------------------
   always_comb begin
      rd_data = '0;                                   // Unmapped reads zero
      case (wb_adr)
         REG_CTRL: begin
            rd_data[CTRL_BAR_EN]    = bar_en_q;
            rd_data[CTRL_SPRITE_EN] = sprite_en_q;
            rd_data[CTRL_GRAY_EN]   = gray_en_q;
         end
         REG_BG_COLOR:     rd_data[11:0] = bg_color_q;
         REG_SPRITE_POS:   rd_data = {5'b0, sprite_y_q, 5'b0, sprite_x_q};
         REG_SPRITE_COLOR: rd_data[11:0] = sprite_color_q;
         REG_FRAME_CNT:    rd_data = frame_cnt_q;
         default:          rd_data = '0;
      endcase
   end

   // ----------------------------------------------------------
   // Bus handshake and register writes
   // ----------------------------------------------------------
   always_ff @(posedge pixel_clk) begin
      if (reset) begin
         wb_ack         <= 1'b0;
         wb_dat_r       <= '0;
         bar_en_q       <= 1'b0;
         sprite_en_q    <= 1'b0;
         gray_en_q      <= 1'b0;
         bg_color_q     <= '0;
         sprite_x_q     <= '0;
         sprite_y_q     <= '0;
         sprite_color_q <= '0;
      end else begin
         wb_ack <= wb_req;                            // Single cycle, no wait states
         if (wb_req) wb_dat_r <= rd_data;
         if (wb_req && wb_we) begin
            case (wb_adr)
               REG_CTRL: begin
                  bar_en_q    <= wb_dat_w[CTRL_BAR_EN];
                  sprite_en_q <= wb_dat_w[CTRL_SPRITE_EN];
                  gray_en_q   <= wb_dat_w[CTRL_GRAY_EN];
               end
               REG_BG_COLOR: bg_color_q <= wb_dat_w[11:0];
               REG_SPRITE_POS: begin
                  sprite_x_q <= wb_dat_w[10:0];
                  sprite_y_q <= wb_dat_w[26:16];
               end
               REG_SPRITE_COLOR: sprite_color_q <= wb_dat_w[11:0];
               default: ;                             // Frame count is read only
            endcase
         end
      end
   end

   // Frame counter
   always_ff @(posedge pixel_clk) begin
      if (reset)            frame_cnt_q <= '0;
      else if (frame_start) frame_cnt_q <= frame_cnt_q + 1'b1;
   end

   // Fields straight to the pipeline
   assign cfg.bar_en       = bar_en_q;
   assign cfg.sprite_en    = sprite_en_q;
   assign cfg.gray_en      = gray_en_q;
   assign cfg.bg_color     = bg_color_q;
   assign cfg.sprite_x     = sprite_x_q;
   assign cfg.sprite_y     = sprite_y_q;
   assign cfg.sprite_color = sprite_color_q;

endmodule

// File: verilog/vga_timing.sv
// VGA raster timing generator

`timescale 1ns/1ps

module vga_timing #(
   parameter int H_ACTIVE = 640,
   parameter int H_FRONT  = 16,
   parameter int H_SYNC   = 96,
   parameter int H_BACK   = 48,
   parameter int V_ACTIVE = 480,
   parameter int V_FRONT  = 10,
   parameter int V_SYNC   = 2,
   parameter int V_BACK   = 33
) (
   input  logic  pixel_clk,
   input  logic  reset,
   pixel_if.src  pix,
   output logic  frame_start     // Line 0, column 0
);

   import video_pkg::*;

   localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
   localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

   coord_t h_cnt, v_cnt;
   logic   h_end, v_end;
   logic   hs_on, vs_on;

   assign h_end = (h_cnt == coord_t'(H_TOTAL - 1));
   assign v_end = (v_cnt == coord_t'(V_TOTAL - 1));

   // ----------------------------------------------------------
   // Column and line counters
   // ----------------------------------------------------------
   always_ff @(posedge pixel_clk) begin
      if (reset) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (h_end) begin
         h_cnt <= '0;
         v_cnt <= v_end ? '0 : v_cnt + 1'b1;  // Wrap at frame end
      end else begin
         h_cnt <= h_cnt + 1'b1;
      end
   end

   // Sync windows follow the front porch
   assign hs_on = (h_cnt >= coord_t'(H_ACTIVE + H_FRONT)) &&
                  (h_cnt <  coord_t'(H_ACTIVE + H_FRONT + H_SYNC));
   assign vs_on = (v_cnt >= coord_t'(V_ACTIVE + V_FRONT)) &&
                  (v_cnt <  coord_t'(V_ACTIVE + V_FRONT + V_SYNC));

   // ----------------------------------------------------------
   // Registered raster outputs
   // ----------------------------------------------------------
   always_ff @(posedge pixel_clk) begin
      if (reset) begin
         pix.de      <= 1'b0;
         pix.hsync   <= 1'b1;              // Idle high
         pix.vsync   <= 1'b1;
         frame_start <= 1'b0;
      end else begin
         pix.de      <= (h_cnt < coord_t'(H_ACTIVE)) && (v_cnt < coord_t'(V_ACTIVE));
         pix.hsync   <= ~hs_on;
         pix.vsync   <= ~vs_on;
         frame_start <= (h_cnt == '0) && (v_cnt == '0);
      end
   end

   always_ff @(posedge pixel_clk) begin
      pix.x <= h_cnt;
      pix.y <= v_cnt;
   end

   assign pix.rgb = '0;                   // Colour comes from later stages

endmodule

// File: verilog/color_bar_gen.sv
// Colour bar stage

`timescale 1ns/1ps

module color_bar_gen #(
   parameter int H_ACTIVE = 640
) (
   input  logic       pixel_clk,
   input  logic       reset,
   pixel_if.dst       pix_in,
   pixel_if.src       pix_out,
   video_cfg_if.user  cfg
);

   import video_pkg::*;

   localparam int BAR_W = H_ACTIVE / NUM_BARS;  // Pixels per bar

   logic [2:0] bar_idx;
   rgb12_t     bar_rgb;
   rgb12_t     pix_rgb;

   // Bar index from column
   assign bar_idx = 3'(pix_in.x / coord_t'(BAR_W));

   // Index bits select full channels
   assign bar_rgb = {{4{bar_idx[2]}},     // Red
                     {4{bar_idx[1]}},     // Green
                     {4{bar_idx[0]}}};    // Blue

   always_comb begin
      if (!pix_in.de)      pix_rgb = '0;  // Blank
      else if (cfg.bar_en) pix_rgb = bar_rgb;
      else                 pix_rgb = cfg.bg_color;
   end

   // ----------------------------------------------------------
   // Stage register
   // ----------------------------------------------------------
   always_ff @(posedge pixel_clk) begin
      if (reset) begin
         pix_out.de    <= 1'b0;
         pix_out.hsync <= 1'b1;
         pix_out.vsync <= 1'b1;
      end else begin
         pix_out.de    <= pix_in.de;
         pix_out.hsync <= pix_in.hsync;
         pix_out.vsync <= pix_in.vsync;
      end
   end

   always_ff @(posedge pixel_clk) begin
      pix_out.x   <= pix_in.x;
      pix_out.y   <= pix_in.y;
      pix_out.rgb <= pix_rgb;
   end

endmodule

// File: verilog/sprite_overlay.sv
// Square sprite overlay stage

`timescale 1ns/1ps

module sprite_overlay (
   input  logic       pixel_clk,
   input  logic       reset,
   pixel_if.dst       pix_in,
   pixel_if.src       pix_out,
   video_cfg_if.user  cfg
);

   import video_pkg::*;

   coord_t dx, dy;
   logic   in_x, in_y;
   logic   hit;
   rgb12_t pix_rgb;

   // Offsets into the square, wrap avoided by the >= test
   assign dx = pix_in.x - cfg.sprite_x;
   assign dy = pix_in.y - cfg.sprite_y;

   assign in_x = (pix_in.x >= cfg.sprite_x) && (dx < coord_t'(SPRITE_SIZE));
   assign in_y = (pix_in.y >= cfg.sprite_y) && (dy < coord_t'(SPRITE_SIZE));

   // de limits the square to the active area
   assign hit = cfg.sprite_en & pix_in.de & in_x & in_y;

   assign pix_rgb = hit ? cfg.sprite_color : pix_in.rgb;

   // ----------------------------------------------------------
   // Stage register
   // ----------------------------------------------------------
   always_ff @(posedge pixel_clk) begin
      if (reset) begin
         pix_out.de    <= 1'b0;
         pix_out.hsync <= 1'b1;
         pix_out.vsync <= 1'b1;
      end else begin
         pix_out.de    <= pix_in.de;
         pix_out.hsync <= pix_in.hsync;
         pix_out.vsync <= pix_in.vsync;
      end
   end

   always_ff @(posedge pixel_clk) begin
      pix_out.x   <= pix_in.x;
      pix_out.y   <= pix_in.y;
      pix_out.rgb <= pix_rgb;
   end

endmodule

// File: verilog/rgb_to_gray.sv
// Grey conversion and VGA output stage

`timescale 1ns/1ps

module rgb_to_gray (
   input  logic                pixel_clk,
   input  logic                reset,
   pixel_if.dst                pix_in,
   video_cfg_if.user           cfg,
   output video_pkg::channel_t vga_r,
   output video_pkg::channel_t vga_g,
   output video_pkg::channel_t vga_b,
   output logic                vga_hsync,
   output logic                vga_vsync,
   output logic                vga_de
);

   import video_pkg::*;

   channel_t   r, g, b;
   logic [7:0] gray_sum;          // Max 16 * 15
   channel_t   gray;

   assign r = pix_in.rgb[11:8];
   assign g = pix_in.rgb[7:4];
   assign b = pix_in.rgb[3:0];

   // Weighted sum, weights total 16
   assign gray_sum = 8'(GRAY_WR) * r + 8'(GRAY_WG) * g + 8'(GRAY_WB) * b;
   assign gray     = gray_sum[7:4];

   // ----------------------------------------------------------
   // Output registers
   // ----------------------------------------------------------
   always_ff @(posedge pixel_clk) begin
      if (reset) begin
         vga_r     <= '0;
         vga_g     <= '0;
         vga_b     <= '0;
         vga_hsync <= 1'b1;
         vga_vsync <= 1'b1;
         vga_de    <= 1'b0;
      end else begin
         vga_r     <= cfg.gray_en ? gray : r;
         vga_g     <= cfg.gray_en ? gray : g;
         vga_b     <= cfg.gray_en ? gray : b;
         vga_hsync <= pix_in.hsync;  // Same lag as colour
         vga_vsync <= pix_in.vsync;
         vga_de    <= pix_in.de;
      end
   end

endmodule

// File: verilog/video_system.sv
// VGA video subsystem top

`timescale 1ns/1ps

module video_system #(
   // Default raster is 640x480 at 60 Hz
   parameter int H_ACTIVE = 640,
   parameter int H_FRONT  = 16,
   parameter int H_SYNC   = 96,
   parameter int H_BACK   = 48,
   parameter int V_ACTIVE = 480,
   parameter int V_FRONT  = 10,
   parameter int V_SYNC   = 2,
   parameter int V_BACK   = 33
) (
   input  logic                      pixel_clk,
   input  logic                      reset,
   // Wishbone slave
   input  logic                      wb_cyc,
   input  logic                      wb_stb,
   input  logic                      wb_we,
   input  video_regs_pkg::wb_addr_t  wb_adr,
   input  video_regs_pkg::wb_data_t  wb_dat_w,
   output video_regs_pkg::wb_data_t  wb_dat_r,
   output logic                      wb_ack,
   // VGA
   output video_pkg::channel_t       vga_r,
   output video_pkg::channel_t       vga_g,
   output video_pkg::channel_t       vga_b,
   output logic                      vga_hsync,
   output logic                      vga_vsync,
   output logic                      vga_de
);

   pixel_if     pix_tim ();    // Timing to bars
   pixel_if     pix_bar ();    // Bars to sprite
   pixel_if     pix_spr ();    // Sprite to grey
   video_cfg_if cfg ();
   logic        frame_start;

   // ----------------------------------------------------------
   // Register block
   // ----------------------------------------------------------
   video_ctrl_regs u_video_ctrl_regs (
      .pixel_clk   (pixel_clk),
      .reset       (reset),
      .wb_cyc      (wb_cyc),
      .wb_stb      (wb_stb),
      .wb_we       (wb_we),
      .wb_adr      (wb_adr),
      .wb_dat_w    (wb_dat_w),
      .wb_dat_r    (wb_dat_r),
      .wb_ack      (wb_ack),
      .frame_start (frame_start),
      .cfg         (cfg.regs)
   );

   // ----------------------------------------------------------
   // Pixel pipeline
   // ----------------------------------------------------------
   vga_timing #(
      .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
      .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
   ) u_vga_timing (
      .pixel_clk   (pixel_clk),
      .reset       (reset),
      .pix         (pix_tim.src),
      .frame_start (frame_start)
   );

   color_bar_gen #(.H_ACTIVE (H_ACTIVE)) u_color_bar_gen (
      .pixel_clk (pixel_clk),
      .reset     (reset),
      .pix_in    (pix_tim.dst),
      .pix_out   (pix_bar.src),
      .cfg       (cfg.user)
   );

   sprite_overlay u_sprite_overlay (
      .pixel_clk (pixel_clk),
      .reset     (reset),
      .pix_in    (pix_bar.dst),
      .pix_out   (pix_spr.src),
      .cfg       (cfg.user)
   );

   rgb_to_gray u_rgb_to_gray (
      .pixel_clk (pixel_clk),
      .reset     (reset),
      .pix_in    (pix_spr.dst),
      .cfg       (cfg.user),
      .vga_r     (vga_r),
      .vga_g     (vga_g),
      .vga_b     (vga_b),
      .vga_hsync (vga_hsync),
      .vga_vsync (vga_vsync),
      .vga_de    (vga_de)
   );

endmodule

// File: sim/tb_video_system.sv
// Testbench for the VGA video subsystem

`timescale 1ns/1ps

module tb_video_system;

   import video_pkg::*;
   import video_regs_pkg::*;

   // Tiny raster, 40 x 16 totals
   localparam int  H_ACTIVE = 32, H_FRONT = 2, H_SYNC = 4, H_BACK = 2;
   localparam int  V_ACTIVE = 12, V_FRONT = 1, V_SYNC = 2, V_BACK = 1;
   localparam int  H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
   localparam int  FRAME_CYCLES = H_TOTAL * (V_ACTIVE + V_FRONT + V_SYNC + V_BACK);
   localparam time CLK_PERIOD = 100;
   localparam int  RUN_FRAMES = 12;   // Seven judged frames, counter test, margin
   localparam int  ACK_LIMIT  = 20;

   logic     pixel_clk = 1'b0;
   logic     reset;
   logic     wb_cyc, wb_stb, wb_we;
   wb_addr_t wb_adr;
   wb_data_t wb_dat_w, wb_dat_r;
   logic     wb_ack;
   channel_t vga_r, vga_g, vga_b;
   logic     vga_hsync, vga_vsync, vga_de;

   // Copy of the register contents
   logic   sh_bar_en, sh_sprite_en, sh_gray_en;
   rgb12_t sh_bg, sh_scolor;
   int     sh_sx, sh_sy;

   int     errors = 0;
   int     checked = 0;                 // Pixels compared this frame
   int     total_checked = 0;
   int     reads = 0;
   int     vs_falls = 0;                // Output vsync falling edges
   int     px = 0, py = 0;              // Raster position seen at outputs
   int     hs_low = 0, vs_low = 0;      // Sync pulse widths in cycles
   int     blank_cnt = 0;               // Blank cycles since last active pixel
   logic   prev_hs = 1'b1, prev_vs = 1'b1, line_act = 1'b0;
   logic   check_en = 1'b0;
   integer seed = 51273;

   video_system #(
      .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
      .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
   ) i_dut (
      .pixel_clk (pixel_clk), .reset (reset),
      .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
      .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
      .vga_r (vga_r), .vga_g (vga_g), .vga_b (vga_b),
      .vga_hsync (vga_hsync), .vga_vsync (vga_vsync), .vga_de (vga_de)
   );

   always #(CLK_PERIOD / 2) pixel_clk = ~pixel_clk;

   // ----------------------------------------------------------
   // Expected picture
   // ----------------------------------------------------------
   function automatic rgb12_t ref_pixel(input int x, input int y);
      rgb12_t pix;
      int     bar;
      bar = x / (H_ACTIVE / NUM_BARS);
      if (sh_bar_en)
         pix = {((bar & 4) != 0) ? 4'hF : 4'h0,    // Red from index bit 2
                ((bar & 2) != 0) ? 4'hF : 4'h0,
                ((bar & 1) != 0) ? 4'hF : 4'h0};
      else
         pix = sh_bg;
      if (sh_sprite_en && x >= sh_sx && x < sh_sx + SPRITE_SIZE &&
          y >= sh_sy && y < sh_sy + SPRITE_SIZE)
         pix = sh_scolor;                          // Square on top
      return pix;
   endfunction

   // Weights 5, 9, 2 over 16
   function automatic channel_t gray_of(input rgb12_t p);
      int sum;
      sum = GRAY_WR * p[11:8] + GRAY_WG * p[7:4] + GRAY_WB * p[3:0];
      return channel_t'(sum >> 4);
   endfunction

   function automatic wb_data_t pos_word(input int x, input int y);
      return {5'b0, coord_t'(y), 5'b0, coord_t'(x)};
   endfunction

   // ----------------------------------------------------------
   // Wishbone master
   // ----------------------------------------------------------
   task automatic wait_ack();
      int n;
      n = 0;
      @(posedge pixel_clk);
      while (wb_ack !== 1'b1 && n < ACK_LIMIT) begin
         @(posedge pixel_clk);
         n++;
      end
      if (wb_ack !== 1'b1) begin
         $display("Wishbone access to 0x%h got no ack within %0d cycles", wb_adr, ACK_LIMIT);
         errors++;
      end
   endtask

   task automatic write_reg(input wb_addr_t addr, input wb_data_t data);
      @(posedge pixel_clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= 1'b1;
      wb_adr   <= addr;
      wb_dat_w <= data;
      wait_ack();
      wb_cyc   <= 1'b0;                 // Drop on the ack edge
      wb_stb   <= 1'b0;
      wb_we    <= 1'b0;
   endtask

   task automatic read_reg(input wb_addr_t addr, output wb_data_t data);
      @(posedge pixel_clk);
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_we  <= 1'b0;
      wb_adr <= addr;
      wait_ack();
      data   = wb_dat_r;                // Valid with ack
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      reads++;
   endtask

   task automatic check_reg(input wb_addr_t addr, input wb_data_t exp);
      wb_data_t got;
      read_reg(addr, got);
      if (got !== exp) begin
         $display("ERR wb_dat_r at 0x%h expected 0x%h actual 0x%h", addr, exp, got);
         errors++;
      end
   endtask

   // Bus write plus copy update
   task automatic set_reg(input wb_addr_t addr, input wb_data_t data);
      write_reg(addr, data);
      case (addr)
         REG_CTRL: begin
            sh_bar_en    = data[CTRL_BAR_EN];
            sh_sprite_en = data[CTRL_SPRITE_EN];
            sh_gray_en   = data[CTRL_GRAY_EN];
         end
         REG_BG_COLOR:     sh_bg = data[11:0];
         REG_SPRITE_POS: begin
            sh_sx = data[10:0];
            sh_sy = data[26:16];
         end
         REG_SPRITE_COLOR: sh_scolor = data[11:0];
         default: ;
      endcase
   endtask

   task automatic wait_vsyncs(input int n);
      int target;
      target = vs_falls + n;
      wait (vs_falls >= target);
   endtask

   // Starts right after a vsync fall, so the whole next frame is judged
   task automatic judge_frame(input string what);
      checked  = 0;
      check_en = 1'b1;
      wait_vsyncs(1);
      check_en = 1'b0;
      if (checked != H_ACTIVE * V_ACTIVE) begin
         $display("%s: %0d active pixels seen in the frame, expected %0d",
                  what, checked, H_ACTIVE * V_ACTIVE);
         errors++;
      end
      total_checked += checked;
   endtask

   // ----------------------------------------------------------
   // Output checker, samples away from the driving edge
   // ----------------------------------------------------------
   always @(negedge pixel_clk) begin : pixel_check
      rgb12_t   exp_rgb;
      channel_t exp_r, exp_g, exp_b;
      if (prev_vs && !vga_vsync) begin   // New frame
         vs_falls++;
         py = 0;
      end
      if (prev_hs && !vga_hsync) begin   // New line
         if (line_act && blank_cnt != H_FRONT) begin
            $display("ERR vga_hsync front porch expected 0x%h actual 0x%h",
                     H_FRONT, blank_cnt);
            errors++;
         end
         px = 0;
         if (line_act) py++;
         line_act = 1'b0;
      end
      if (!prev_hs && vga_hsync) begin   // Line sync over
         if (hs_low != H_SYNC) begin
            $display("ERR vga_hsync low width expected 0x%h actual 0x%h", H_SYNC, hs_low);
            errors++;
         end
         hs_low = 0;
      end
      if (!prev_vs && vga_vsync) begin   // Frame sync over
         if (vs_low != V_SYNC * H_TOTAL) begin
            $display("ERR vga_vsync low width expected 0x%h actual 0x%h",
                     V_SYNC * H_TOTAL, vs_low);
            errors++;
         end
         vs_low = 0;
      end
      if (vga_de && check_en) begin
         if (px >= H_ACTIVE || py >= V_ACTIVE) begin
            $display("Active pixel outside the raster at x %0d y %0d", px, py);
            errors++;
         end
         exp_rgb = ref_pixel(px, py);
         exp_r   = sh_gray_en ? gray_of(exp_rgb) : exp_rgb[11:8];
         exp_g   = sh_gray_en ? gray_of(exp_rgb) : exp_rgb[7:4];
         exp_b   = sh_gray_en ? gray_of(exp_rgb) : exp_rgb[3:0];
         if (sh_gray_en && (vga_r !== vga_g || vga_g !== vga_b)) begin
            $display("ERR vga_g/vga_b differ from vga_r in grey mode: 0x%h 0x%h 0x%h",
                     vga_r, vga_g, vga_b);
            errors++;
         end
         if (vga_r !== exp_r) begin
            $display("ERR vga_r x %0d y %0d expected 0x%h actual 0x%h", px, py, exp_r, vga_r);
            errors++;
         end
         if (vga_g !== exp_g) begin
            $display("ERR vga_g x %0d y %0d expected 0x%h actual 0x%h", px, py, exp_g, vga_g);
            errors++;
         end
         if (vga_b !== exp_b) begin
            $display("ERR vga_b x %0d y %0d expected 0x%h actual 0x%h", px, py, exp_b, vga_b);
            errors++;
         end
         checked++;
      end
      if (vga_de) begin
         px++;
         line_act  = 1'b1;
         blank_cnt = 0;
      end else begin
         blank_cnt++;
      end
      if (!vga_hsync) hs_low++;
      if (!vga_vsync) vs_low++;
      prev_hs = vga_hsync;
      prev_vs = vga_vsync;
   end

   // ----------------------------------------------------------
   // Test sequence
   // ----------------------------------------------------------
   initial begin : main
      wb_data_t c1, c2;
      int       v1, v2, sx, sy;
      reset    = 1'b1;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      {sh_bar_en, sh_sprite_en, sh_gray_en} = 3'b000;
      sh_bg     = '0;
      sh_scolor = '0;
      sh_sx     = 0;
      sh_sy     = 0;
      repeat (4) @(posedge pixel_clk);
      reset <= 1'b0;

      // First frame_start lands on the same edge as this read
      check_reg(REG_FRAME_CNT, '0);
      check_reg(REG_CTRL, '0);
      check_reg(REG_BG_COLOR, '0);
      check_reg(REG_SPRITE_POS, '0);
      check_reg(REG_SPRITE_COLOR, '0);
      check_reg(8'h14, '0);                        // Unmapped
      wait_vsyncs(1);
      judge_frame("reset picture");

      set_reg(REG_BG_COLOR, 32'h0000_0A5C);
      check_reg(REG_BG_COLOR, 32'h0000_0A5C);
      judge_frame("background colour");

      set_reg(REG_CTRL, 32'(1) << CTRL_BAR_EN);
      judge_frame("colour bars");

      sx = $unsigned($random(seed)) % (H_ACTIVE - SPRITE_SIZE + 1);
      sy = $unsigned($random(seed)) % (V_ACTIVE - SPRITE_SIZE + 1);
      set_reg(REG_SPRITE_POS, pos_word(sx, sy));
      set_reg(REG_SPRITE_COLOR, wb_data_t'($random(seed)) & 32'h0000_0FFF);
      set_reg(REG_CTRL, (32'(1) << CTRL_BAR_EN) | (32'(1) << CTRL_SPRITE_EN));
      check_reg(REG_SPRITE_POS, pos_word(sx, sy));
      judge_frame("random sprite");

      set_reg(REG_SPRITE_POS, pos_word(H_ACTIVE - 3, V_ACTIVE - 4));  // Clipped corner
      judge_frame("clipped sprite");

      set_reg(REG_CTRL, 32'h7);                    // Bars, sprite, grey
      judge_frame("grey bars and sprite");
      set_reg(REG_CTRL, 32'(1) << CTRL_GRAY_EN);
      judge_frame("grey background");

      // Frame counter against counted vsync edges
      read_reg(REG_FRAME_CNT, c1);
      v1 = vs_falls;
      wait_vsyncs(2);
      read_reg(REG_FRAME_CNT, c2);
      v2 = vs_falls;
      if (c2 - c1 != wb_data_t'(v2 - v1)) begin
         $display("ERR wb_dat_r frame count step expected 0x%h actual 0x%h",
                  wb_data_t'(v2 - v1), c2 - c1);
         errors++;
      end

      $display("Errors: %0d, pixels checked: %0d, register reads: %0d",
               errors, total_checked, reads);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

   // Watchdog
   initial begin
      #(RUN_FRAMES * FRAME_CYCLES * CLK_PERIOD);
      $display("Timeout: test sequence did not finish within %0d frames", RUN_FRAMES);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

// File: verilog.f
verilog/video_pkg.sv
verilog/video_regs_pkg.sv
verilog/pixel_if.sv
verilog/video_cfg_if.sv
verilog/video_ctrl_regs.sv
verilog/vga_timing.sv
verilog/color_bar_gen.sv
verilog/sprite_overlay.sv
verilog/rgb_to_gray.sv
verilog/video_system.sv
sim/tb_video_system.sv

// File: Bender.yml
package:
  name: video_system

sources:
  - verilog/video_pkg.sv
  - verilog/video_regs_pkg.sv
  - verilog/pixel_if.sv
  - verilog/video_cfg_if.sv
  - verilog/video_ctrl_regs.sv
  - verilog/vga_timing.sv
  - verilog/color_bar_gen.sv
  - verilog/sprite_overlay.sv
  - verilog/rgb_to_gray.sv
  - verilog/video_system.sv
  - target: simulation
    files:
      - sim/tb_video_system.sv
